//--- source/l2_cache_pkg.sv
//--------------------------------------------------------------------------
// L2 cache shared definitions
// Word, line and address types and the fixed cache geometry
//--------------------------------------------------------------------------

package l2_cache_pkg;

	// Data word size in bits
	localparam int WORD_WIDTH = 32;

	// Words per cache line
	localparam int LINE_WORDS = 4;

	// Ways per set, fixed by the 3-bit pseudo-LRU tree
	localparam int NUM_WAYS = 4;

	// Byte offset within a line
	localparam int OFFSET_BITS = 4;

	// One data word
	typedef logic [WORD_WIDTH - 1:0] word_t;

	// One cache line, word 0 in the low bits
	typedef word_t [LINE_WORDS - 1:0] line_t;

	// Byte address from the client
	typedef logic [31:0] addr_t;

	// Way number within a set
	typedef logic [1:0] way_idx_t;

endpackage

//--- source/sram_1r1w.sv
//--------------------------------------------------------------------------
// One-read one-write synchronous memory
// Registered read, read-during-write returns old or new data
//--------------------------------------------------------------------------

module sram_1r1w
	#(parameter type DATA_TYPE = logic,
	parameter int SIZE = 16,
	parameter bit READ_NEW_DATA = 1'b0,
	localparam int ADDR_WIDTH = $clog2(SIZE))
	(input clk,

	// Read port
	input read_en,
	input [ADDR_WIDTH - 1:0] read_addr,
	output DATA_TYPE read_data,

	// Write port
	input write_en,
	input [ADDR_WIDTH - 1:0] write_addr,
	input DATA_TYPE write_data);

	// Storage array
	DATA_TYPE data[SIZE];

	always_ff @(posedge clk)
	begin
		if (write_en)
			data[write_addr] <= write_data;

		if (read_en)
		begin
			// Forward the write on an address collision if asked to
			if (READ_NEW_DATA && write_en && write_addr == read_addr)
				read_data <= write_data;
			else
				read_data <= data[read_addr];
		end
	end

endmodule

//--- source/cache_lru.sv
//--------------------------------------------------------------------------
// Tree pseudo-LRU for four ways
// Picks fill victims and marks ways most recently used
//--------------------------------------------------------------------------

module cache_lru
	#(parameter int NUM_SETS = 16,
	localparam int SET_INDEX_WIDTH = $clog2(NUM_SETS))
	(input clk,
	input reset,

	// Victim lookup for fills
	input fill_en,
	input [SET_INDEX_WIDTH - 1:0] fill_set,
	output l2_cache_pkg::way_idx_t fill_way,

	// Lookup of client accesses
	input access_en,
	input [SET_INDEX_WIDTH - 1:0] access_set,

	// Hit way reported back one cycle later
	input access_update_en,
	input l2_cache_pkg::way_idx_t access_update_way);

	// Tree bits per set, [2] root, [1] left pair, [0] right pair
	logic [2:0] tree_bits[NUM_SETS];

	// Set of the access now in the read stage
	logic [SET_INDEX_WIDTH - 1:0] update_set;

	logic [2:0] hit_bits;
	logic [2:0] fill_bits;
	l2_cache_pkg::way_idx_t victim;

	// Follow the tree towards the least recently used way
	function automatic l2_cache_pkg::way_idx_t pick_victim(input logic [2:0] bits);
		if (bits[2])
			return {1'b1, bits[0]};
		else
			return {1'b0, bits[1]};
	endfunction

	// Point every bit on the path away from the used way
	function automatic logic [2:0] mark_used(input logic [2:0] bits,
		input l2_cache_pkg::way_idx_t way);
		logic [2:0] result;

		result = bits;
		result[2] = !way[1];
		if (way[1])
			result[0] = !way[0];
		else
			result[1] = !way[0];
		return result;
	endfunction

	always_comb
	begin
		hit_bits = mark_used(tree_bits[update_set], access_update_way);

		// Fill sees a same-cycle hit update to its set
		if (access_update_en && update_set == fill_set)
			fill_bits = hit_bits;
		else
			fill_bits = tree_bits[fill_set];

		victim = pick_victim(fill_bits);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int set_idx = 0; set_idx < NUM_SETS; set_idx++)
				tree_bits[set_idx] <= 3'b000;
			update_set <= '0;
			fill_way <= '0;
		end
		else
		begin
			if (access_en)
				update_set <= access_set;

			if (access_update_en)
				tree_bits[update_set] <= hit_bits;

			// Fill write comes last so it wins on the same set
			if (fill_en)
			begin
				tree_bits[fill_set] <= mark_used(fill_bits, victim);
				fill_way <= victim;
			end
		end
	end

endmodule

//--- source/l2_cache_tag.sv
//--------------------------------------------------------------------------
// L2 cache tag stage
// Reads tags, valid and dirty bits and LRU victim for the next stage
//--------------------------------------------------------------------------

module l2_cache_tag
	#(parameter int NUM_SETS = 16,
	localparam int SET_INDEX_WIDTH = $clog2(NUM_SETS),
	localparam int TAG_WIDTH = $bits(l2_cache_pkg::addr_t) - SET_INDEX_WIDTH
		- l2_cache_pkg::OFFSET_BITS)
	(input clk,
	input reset,

	// Client access
	input request_valid,
	input request_store,
	input l2_cache_pkg::addr_t request_address,
	input l2_cache_pkg::word_t request_store_data,

	// Line fill from memory
	input fill_valid,
	input l2_cache_pkg::addr_t fill_address,
	input l2_cache_pkg::line_t fill_data,

	// Metadata updates from the read stage
	input [l2_cache_pkg::NUM_WAYS - 1:0] update_tag_en,
	input [SET_INDEX_WIDTH - 1:0] update_tag_set,
	input update_tag_valid,
	input [TAG_WIDTH - 1:0] update_tag_value,
	input [l2_cache_pkg::NUM_WAYS - 1:0] update_dirty_en,
	input [SET_INDEX_WIDTH - 1:0] update_dirty_set,
	input update_dirty_value,
	input update_lru_en,
	input l2_cache_pkg::way_idx_t update_lru_way,

	// To the read stage
	output logic stage_valid,
	output logic stage_is_fill,
	output logic stage_store,
	output l2_cache_pkg::addr_t stage_address,
	output l2_cache_pkg::word_t stage_store_data,
	output l2_cache_pkg::line_t stage_fill_data,
	output logic way_valid[l2_cache_pkg::NUM_WAYS],
	output logic [TAG_WIDTH - 1:0] way_tag[l2_cache_pkg::NUM_WAYS],
	output logic way_dirty[l2_cache_pkg::NUM_WAYS],
	output l2_cache_pkg::way_idx_t fill_way);

	logic lookup_en;
	l2_cache_pkg::addr_t lookup_address;
	logic [SET_INDEX_WIDTH - 1:0] lookup_set;

	// Requests and fills never overlap, so one lookup port
	assign lookup_en = request_valid || fill_valid;
	assign lookup_address = fill_valid ? fill_address : request_address;
	assign lookup_set = lookup_address[l2_cache_pkg::OFFSET_BITS +: SET_INDEX_WIDTH];

	cache_lru #(.NUM_SETS(NUM_SETS)) lru(
		.clk,
		.reset,
		.fill_en(fill_valid),
		.fill_set(lookup_set),
		.fill_way,
		.access_en(request_valid),
		.access_set(lookup_set),
		.access_update_en(update_lru_en),
		.access_update_way(update_lru_way));

	// Per-way metadata
	for (genvar way = 0; way < l2_cache_pkg::NUM_WAYS; way++)
	begin : way_gen
		// Valid bits live in flops so reset clears them
		logic line_valid[NUM_SETS];

		sram_1r1w #(
			.DATA_TYPE(logic [TAG_WIDTH - 1:0]),
			.SIZE(NUM_SETS),
			.READ_NEW_DATA(1'b1)
		) tag_sram(
			.clk,
			.read_en(lookup_en),
			.read_addr(lookup_set),
			.read_data(way_tag[way]),
			.write_en(update_tag_en[way]),
			.write_addr(update_tag_set),
			.write_data(update_tag_value));

		sram_1r1w #(
			.DATA_TYPE(logic),
			.SIZE(NUM_SETS),
			.READ_NEW_DATA(1'b1)
		) dirty_sram(
			.clk,
			.read_en(lookup_en),
			.read_addr(lookup_set),
			.read_data(way_dirty[way]),
			.write_en(update_dirty_en[way]),
			.write_addr(update_dirty_set),
			.write_data(update_dirty_value));

		always_ff @(posedge clk, posedge reset)
		begin
			if (reset)
			begin
				for (int set_idx = 0; set_idx < NUM_SETS; set_idx++)
					line_valid[set_idx] <= 1'b0;
				way_valid[way] <= 1'b0;
			end
			else
			begin
				if (lookup_en)
				begin
					// Bypass a valid update landing this cycle
					if (update_tag_en[way] && update_tag_set == lookup_set)
						way_valid[way] <= update_tag_valid;
					else
						way_valid[way] <= line_valid[lookup_set];
				end

				if (update_tag_en[way])
					line_valid[update_tag_set] <= update_tag_valid;
			end
		end
	end

	// Pipeline control
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			stage_valid <= 1'b0;
			stage_is_fill <= 1'b0;
		end
		else
		begin
			stage_valid <= lookup_en;
			stage_is_fill <= fill_valid;
		end
	end

	// Access fields and fill line
	always_ff @(posedge clk)
	begin
		stage_store <= request_store;
		stage_address <= lookup_address;
		stage_store_data <= request_store_data;
		stage_fill_data <= fill_data;
	end

	// No arbiter in front, the memory side must hold off fills
	assert property (@(posedge clk) disable iff (reset)
		!(request_valid && fill_valid));

endmodule

//--- source/l2_cache_read.sv
//--------------------------------------------------------------------------
// L2 cache read stage
// Tag compare, data array, metadata updates, responses and writebacks
//--------------------------------------------------------------------------

module l2_cache_read
	#(parameter int NUM_SETS = 16,
	localparam int SET_INDEX_WIDTH = $clog2(NUM_SETS),
	localparam int TAG_WIDTH = $bits(l2_cache_pkg::addr_t) - SET_INDEX_WIDTH
		- l2_cache_pkg::OFFSET_BITS)
	(input clk,
	input reset,

	// From the tag stage
	input stage_valid,
	input stage_is_fill,
	input stage_store,
	input l2_cache_pkg::addr_t stage_address,
	input l2_cache_pkg::word_t stage_store_data,
	input l2_cache_pkg::line_t stage_fill_data,
	input way_valid[l2_cache_pkg::NUM_WAYS],
	input [TAG_WIDTH - 1:0] way_tag[l2_cache_pkg::NUM_WAYS],
	input way_dirty[l2_cache_pkg::NUM_WAYS],
	input l2_cache_pkg::way_idx_t fill_way,

	// Metadata updates back to the tag stage
	output logic [l2_cache_pkg::NUM_WAYS - 1:0] update_tag_en,
	output logic [SET_INDEX_WIDTH - 1:0] update_tag_set,
	output logic update_tag_valid,
	output logic [TAG_WIDTH - 1:0] update_tag_value,
	output logic [l2_cache_pkg::NUM_WAYS - 1:0] update_dirty_en,
	output logic [SET_INDEX_WIDTH - 1:0] update_dirty_set,
	output logic update_dirty_value,
	output logic update_lru_en,
	output l2_cache_pkg::way_idx_t update_lru_way,

	// Result strobes
	output logic response_valid,
	output l2_cache_pkg::word_t response_data,
	output logic miss_valid,
	output l2_cache_pkg::addr_t miss_address,
	output logic writeback_valid,
	output l2_cache_pkg::addr_t writeback_address,
	output l2_cache_pkg::line_t writeback_data);

	localparam int BYTE_BITS = $clog2(l2_cache_pkg::WORD_WIDTH / 8);
	localparam int WORD_INDEX_WIDTH = $clog2(l2_cache_pkg::LINE_WORDS);

	logic [SET_INDEX_WIDTH - 1:0] stage_set;
	logic [TAG_WIDTH - 1:0] stage_tag;
	logic [WORD_INDEX_WIDTH - 1:0] stage_word;
	logic is_request;
	logic is_fill;
	logic [l2_cache_pkg::NUM_WAYS - 1:0] hit_oh;
	logic cache_hit;
	l2_cache_pkg::way_idx_t hit_way;
	logic victim_dirty;
	l2_cache_pkg::word_t read_words[l2_cache_pkg::NUM_WAYS][l2_cache_pkg::LINE_WORDS];

	// Second half, waiting on the data array read
	logic pipe_response;
	logic pipe_miss;
	logic pipe_writeback;
	l2_cache_pkg::way_idx_t pipe_way;
	logic [WORD_INDEX_WIDTH - 1:0] pipe_word;
	l2_cache_pkg::addr_t pipe_address;

	// Address fields
	assign stage_set = stage_address[l2_cache_pkg::OFFSET_BITS +: SET_INDEX_WIDTH];
	assign stage_tag = stage_address[l2_cache_pkg::OFFSET_BITS + SET_INDEX_WIDTH +: TAG_WIDTH];
	assign stage_word = stage_address[BYTE_BITS +: WORD_INDEX_WIDTH];

	assign is_request = stage_valid && !stage_is_fill;
	assign is_fill = stage_valid && stage_is_fill;

	// Tag compare
	always_comb
	begin
		hit_way = '0;
		for (int way = 0; way < l2_cache_pkg::NUM_WAYS; way++)
		begin
			hit_oh[way] = way_valid[way] && way_tag[way] == stage_tag;
			if (hit_oh[way])
				hit_way = l2_cache_pkg::way_idx_t'(way);
		end
	end

	assign cache_hit = is_request && |hit_oh;
	assign victim_dirty = way_valid[fill_way] && way_dirty[fill_way];

	// Fills install the tag, store hits and fills touch dirty
	assign update_tag_set = stage_set;
	assign update_tag_valid = 1'b1;
	assign update_tag_value = stage_tag;
	assign update_dirty_set = stage_set;
	assign update_dirty_value = !stage_is_fill;
	assign update_lru_en = cache_hit;
	assign update_lru_way = hit_way;

	for (genvar way = 0; way < l2_cache_pkg::NUM_WAYS; way++)
	begin : way_gen
		assign update_tag_en[way] = is_fill && fill_way == l2_cache_pkg::way_idx_t'(way);
		assign update_dirty_en[way] = update_tag_en[way]
			|| (cache_hit && stage_store && hit_way == l2_cache_pkg::way_idx_t'(way));

		// One word-wide array per way and word, old data for the writeback
		for (genvar word = 0; word < l2_cache_pkg::LINE_WORDS; word++)
		begin : word_gen
			sram_1r1w #(
				.DATA_TYPE(l2_cache_pkg::word_t),
				.SIZE(NUM_SETS),
				.READ_NEW_DATA(1'b0)
			) data_sram(
				.clk,
				.read_en(stage_valid),
				.read_addr(stage_set),
				.read_data(read_words[way][word]),
				.write_en(update_dirty_en[way]
					&& (stage_is_fill || stage_word == WORD_INDEX_WIDTH'(word))),
				.write_addr(stage_set),
				.write_data(stage_is_fill ? stage_fill_data[word] : stage_store_data));
		end
	end

	// Outcome flags registered with the array read
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			pipe_response <= 1'b0;
			pipe_miss <= 1'b0;
			pipe_writeback <= 1'b0;
		end
		else
		begin
			pipe_response <= cache_hit && !stage_store;
			pipe_miss <= is_request && !cache_hit;
			pipe_writeback <= is_fill && victim_dirty;
		end
	end

	always_ff @(posedge clk)
	begin
		pipe_way <= is_fill ? fill_way : hit_way;
		pipe_word <= stage_word;

		// Evicted line address rebuilt from the old tag
		if (is_fill)
			pipe_address <= {way_tag[fill_way], stage_set, {l2_cache_pkg::OFFSET_BITS{1'b0}}};
		else
			pipe_address <= stage_address;
	end

	// Output strobes
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			response_valid <= 1'b0;
			miss_valid <= 1'b0;
			writeback_valid <= 1'b0;
		end
		else
		begin
			response_valid <= pipe_response;
			miss_valid <= pipe_miss;
			writeback_valid <= pipe_writeback;
		end
	end

	// Output data
	always_ff @(posedge clk)
	begin
		response_data <= read_words[pipe_way][pipe_word];
		miss_address <= pipe_address;
		writeback_address <= pipe_address;
		for (int word = 0; word < l2_cache_pkg::LINE_WORDS; word++)
			writeback_data[word] <= read_words[pipe_way][word];
	end

	// Tag stage keeps at most one copy of a line per set
	assert property (@(posedge clk) disable iff (reset)
		stage_valid |-> $onehot0(hit_oh));

endmodule

//--- source/l2_cache.sv
//--------------------------------------------------------------------------
// L2 cache top level
// Two-stage pipeline, tag lookup then data access
//--------------------------------------------------------------------------

module l2_cache
	#(parameter int NUM_SETS = 16,
	localparam int SET_INDEX_WIDTH = $clog2(NUM_SETS),
	localparam int TAG_WIDTH = $bits(l2_cache_pkg::addr_t) - SET_INDEX_WIDTH
		- l2_cache_pkg::OFFSET_BITS)
	(input clk,
	input reset,

	// Client access
	input request_valid,
	input request_store,
	input l2_cache_pkg::addr_t request_address,
	input l2_cache_pkg::word_t request_store_data,

	// Line fill from memory
	input fill_valid,
	input l2_cache_pkg::addr_t fill_address,
	input l2_cache_pkg::line_t fill_data,

	// Load hit data
	output logic response_valid,
	output l2_cache_pkg::word_t response_data,

	// Miss request to memory
	output logic miss_valid,
	output l2_cache_pkg::addr_t miss_address,

	// Dirty line eviction
	output logic writeback_valid,
	output l2_cache_pkg::addr_t writeback_address,
	output l2_cache_pkg::line_t writeback_data);

	// Tag stage to read stage
	logic stage_valid;
	logic stage_is_fill;
	logic stage_store;
	l2_cache_pkg::addr_t stage_address;
	l2_cache_pkg::word_t stage_store_data;
	l2_cache_pkg::line_t stage_fill_data;
	logic way_valid[l2_cache_pkg::NUM_WAYS];
	logic [TAG_WIDTH - 1:0] way_tag[l2_cache_pkg::NUM_WAYS];
	logic way_dirty[l2_cache_pkg::NUM_WAYS];
	l2_cache_pkg::way_idx_t fill_way;

	// Read stage back to tag stage
	logic [l2_cache_pkg::NUM_WAYS - 1:0] update_tag_en;
	logic [SET_INDEX_WIDTH - 1:0] update_tag_set;
	logic update_tag_valid;
	logic [TAG_WIDTH - 1:0] update_tag_value;
	logic [l2_cache_pkg::NUM_WAYS - 1:0] update_dirty_en;
	logic [SET_INDEX_WIDTH - 1:0] update_dirty_set;
	logic update_dirty_value;
	logic update_lru_en;
	l2_cache_pkg::way_idx_t update_lru_way;

	l2_cache_tag #(.NUM_SETS(NUM_SETS)) tag_stage(
		.clk,
		.reset,
		.request_valid,
		.request_store,
		.request_address,
		.request_store_data,
		.fill_valid,
		.fill_address,
		.fill_data,
		.update_tag_en,
		.update_tag_set,
		.update_tag_valid,
		.update_tag_value,
		.update_dirty_en,
		.update_dirty_set,
		.update_dirty_value,
		.update_lru_en,
		.update_lru_way,
		.stage_valid,
		.stage_is_fill,
		.stage_store,
		.stage_address,
		.stage_store_data,
		.stage_fill_data,
		.way_valid,
		.way_tag,
		.way_dirty,
		.fill_way);

	l2_cache_read #(.NUM_SETS(NUM_SETS)) read_stage(
		.clk,
		.reset,
		.stage_valid,
		.stage_is_fill,
		.stage_store,
		.stage_address,
		.stage_store_data,
		.stage_fill_data,
		.way_valid,
		.way_tag,
		.way_dirty,
		.fill_way,
		.update_tag_en,
		.update_tag_set,
		.update_tag_valid,
		.update_tag_value,
		.update_dirty_en,
		.update_dirty_set,
		.update_dirty_value,
		.update_lru_en,
		.update_lru_way,
		.response_valid,
		.response_data,
		.miss_valid,
		.miss_address,
		.writeback_valid,
		.writeback_address,
		.writeback_data);

endmodule

//--- verif/l2_cache_tb.sv
//--------------------------------------------------------------------------
// L2 cache testbench
// Table of accesses and fills with expected strobes at fixed latency
//--------------------------------------------------------------------------

module l2_cache_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_SETS = 16;
	localparam int MAX_ROWS = 64;
	// Row sampled one edge after its drive and checked 2 cycles after that
	localparam int CHECK_DELAY = 3;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_TIMEOUT = 20;
	localparam int DRAIN_TIMEOUT = 8;

	// Row operations
	localparam int OP_IDLE = 0;
	localparam int OP_LOAD = 1;
	localparam int OP_STORE = 2;
	localparam int OP_FILL = 3;

	logic clk = 1'b0;
	logic reset;
	logic request_valid;
	logic request_store;
	l2_cache_pkg::addr_t request_address;
	l2_cache_pkg::word_t request_store_data;
	logic fill_valid;
	l2_cache_pkg::addr_t fill_address;
	l2_cache_pkg::line_t fill_data;
	logic response_valid;
	l2_cache_pkg::word_t response_data;
	logic miss_valid;
	l2_cache_pkg::addr_t miss_address;
	logic writeback_valid;
	l2_cache_pkg::addr_t writeback_address;
	l2_cache_pkg::line_t writeback_data;

	// Stimulus table with one row per cycle
	int num_rows;
	int row_op[MAX_ROWS];
	l2_cache_pkg::addr_t row_address[MAX_ROWS];
	l2_cache_pkg::word_t row_data[MAX_ROWS];
	logic row_response[MAX_ROWS];
	l2_cache_pkg::word_t row_response_data[MAX_ROWS];
	logic row_miss[MAX_ROWS];
	l2_cache_pkg::addr_t row_miss_address[MAX_ROWS];
	logic row_writeback[MAX_ROWS];
	l2_cache_pkg::addr_t row_writeback_address[MAX_ROWS];
	l2_cache_pkg::line_t row_writeback_data[MAX_ROWS];

	l2_cache #(.NUM_SETS(NUM_SETS)) DUT(.*);

	always #4 clk = !clk;

	// Reset held over the first 4 rising edges
	initial
	begin
		reset = 1'b1;
		for (int cycle = 0; cycle < 4; cycle++)
			@(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
	end

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		if (actual !== expected)
			stop_run($sformatf("FAILED at %0d ns: %s is %h, expected %h",
				$time, name, actual, expected));
	endtask

	// Word i of a fill holds the line address plus i
	function automatic l2_cache_pkg::line_t make_line(input l2_cache_pkg::addr_t address);
		l2_cache_pkg::line_t words;
		l2_cache_pkg::addr_t line_address;

		line_address = {address[31:4], 4'h0};
		for (int i = 0; i < l2_cache_pkg::LINE_WORDS; i++)
			words[i] = line_address + i;
		return words;
	endfunction

	task automatic append_row(input int op, input l2_cache_pkg::addr_t address,
		input l2_cache_pkg::word_t data, input logic response,
		input l2_cache_pkg::word_t response_word, input logic miss,
		input l2_cache_pkg::addr_t miss_addr, input logic writeback,
		input l2_cache_pkg::addr_t writeback_addr, input l2_cache_pkg::line_t writeback_line);
		if (num_rows >= MAX_ROWS)
			stop_run("Stimulus table has more rows than it can hold");
		else
		begin
			row_op[num_rows] = op;
			row_address[num_rows] = address;
			row_data[num_rows] = data;
			row_response[num_rows] = response;
			row_response_data[num_rows] = response_word;
			row_miss[num_rows] = miss;
			row_miss_address[num_rows] = miss_addr;
			row_writeback[num_rows] = writeback;
			row_writeback_address[num_rows] = writeback_addr;
			row_writeback_data[num_rows] = writeback_line;
			num_rows++;
		end
	endtask

	// Row shorthands
	task automatic load_hit(input l2_cache_pkg::addr_t address, input l2_cache_pkg::word_t word);
		append_row(OP_LOAD, address, '0, 1'b1, word, 1'b0, '0, 1'b0, '0, '0);
	endtask

	task automatic load_miss(input l2_cache_pkg::addr_t address);
		append_row(OP_LOAD, address, '0, 1'b0, '0, 1'b1, address, 1'b0, '0, '0);
	endtask

	task automatic store_hit(input l2_cache_pkg::addr_t address, input l2_cache_pkg::word_t data);
		append_row(OP_STORE, address, data, 1'b0, '0, 1'b0, '0, 1'b0, '0, '0);
	endtask

	task automatic store_miss(input l2_cache_pkg::addr_t address, input l2_cache_pkg::word_t data);
		append_row(OP_STORE, address, data, 1'b0, '0, 1'b1, address, 1'b0, '0, '0);
	endtask

	// Fill whose victim is empty or clean
	task automatic clean_fill(input l2_cache_pkg::addr_t address);
		append_row(OP_FILL, address, '0, 1'b0, '0, 1'b0, '0, 1'b0, '0, '0);
	endtask

	// Fill whose victim is dirty and goes back to memory
	task automatic dirty_fill(input l2_cache_pkg::addr_t address,
		input l2_cache_pkg::addr_t victim_address, input l2_cache_pkg::line_t victim_line);
		append_row(OP_FILL, address, '0, 1'b0, '0, 1'b0, '0, 1'b1, victim_address, victim_line);
	endtask

	task automatic apply_inputs(input int op, input l2_cache_pkg::addr_t address,
		input l2_cache_pkg::word_t data);
		request_valid = op == OP_LOAD || op == OP_STORE;
		request_store = op == OP_STORE;
		request_address = address;
		request_store_data = data;
		fill_valid = op == OP_FILL;
		fill_address = address;
		fill_data = make_line(address);
	endtask

	// All strobes low while the pipeline is empty
	task automatic check_quiet;
		check_value("response_valid", 128'(response_valid), 128'(0));
		check_value("miss_valid", 128'(miss_valid), 128'(0));
		check_value("writeback_valid", 128'(writeback_valid), 128'(0));
	endtask

	task automatic check_row(input int idx);
		check_value("response_valid", 128'(response_valid), 128'(row_response[idx]));
		if (row_response[idx])
			check_value("response_data", 128'(response_data), 128'(row_response_data[idx]));
		check_value("miss_valid", 128'(miss_valid), 128'(row_miss[idx]));
		if (row_miss[idx])
			check_value("miss_address", 128'(miss_address), 128'(row_miss_address[idx]));
		check_value("writeback_valid", 128'(writeback_valid), 128'(row_writeback[idx]));
		if (row_writeback[idx])
		begin
			check_value("writeback_address", 128'(writeback_address),
				128'(row_writeback_address[idx]));
			check_value("writeback_data", 128'(writeback_data), 128'(row_writeback_data[idx]));
		end
	endtask

	task automatic wait_reset_release;
		int cycles;

		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
			if (cycles > RESET_TIMEOUT)
				stop_run("Timed out waiting for reset to be released");
		end
		while (reset);
	endtask

	// Drive row n and check row n minus CHECK_DELAY in the same cycle
	task automatic run_table;
		int cycle;

		cycle = 0;
		while (cycle < num_rows + CHECK_DELAY)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			if (cycle >= CHECK_DELAY)
				check_row(cycle - CHECK_DELAY);
			else
				check_quiet();
			if (cycle < num_rows)
				apply_inputs(row_op[cycle], row_address[cycle], row_data[cycle]);
			else
				apply_inputs(OP_IDLE, '0, '0);
			cycle++;
		end
	endtask

	// Strobes must stop once the last row has left the pipeline
	task automatic wait_pipeline_drain;
		int cycles;

		cycles = 0;
		while (response_valid || miss_valid || writeback_valid)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
			if (cycles > DRAIN_TIMEOUT)
				stop_run("Timed out waiting for the pipeline to drain");
		end
	endtask

	initial
	begin
		l2_cache_pkg::line_t dirty_line;

		request_valid = 1'b0;
		request_store = 1'b0;
		request_address = '0;
		request_store_data = '0;
		fill_valid = 1'b0;
		fill_address = '0;
		fill_data = '0;
		num_rows = 0;

		// Cold misses then a fill and back to back re-issue in set 1
		load_miss(32'h0000_1014);
		store_miss(32'h0000_0044, 32'h1234_5678);
		clean_fill(32'h0000_1010);
		load_hit(32'h0000_1014, 32'h0000_1011);

		// Store hit on word 2 leaves the other words at their fill values
		store_hit(32'h0000_1018, 32'hdead_beef);
		load_hit(32'h0000_1018, 32'hdead_beef);
		load_hit(32'h0000_101c, 32'h0000_1013);
		load_hit(32'h0000_1010, 32'h0000_1010);

		// Five lines into set 2 take ways 0 2 1 3 and then 0 again
		clean_fill(32'h0000_0020);
		clean_fill(32'h0000_0120);
		clean_fill(32'h0000_0220);
		clean_fill(32'h0000_0320);
		clean_fill(32'h0000_0420);
		load_miss(32'h0000_0024);
		load_hit(32'h0000_0124, 32'h0000_0121);
		load_hit(32'h0000_0228, 32'h0000_0222);
		load_hit(32'h0000_032c, 32'h0000_0323);
		load_hit(32'h0000_0420, 32'h0000_0420);

		// Set 1 tree points at way 2 and three fills bring it back to way 0
		clean_fill(32'h0000_1110);
		clean_fill(32'h0000_1210);
		clean_fill(32'h0000_1310);
		dirty_line = make_line(32'h0000_1010);
		dirty_line[2] = 32'hdead_beef;
		dirty_fill(32'h0000_1410, 32'h0000_1010, dirty_line);
		// Way 2 holds a clean line
		clean_fill(32'h0000_1510);
		load_miss(32'h0000_1110);
		load_hit(32'h0000_1418, 32'h0000_1412);

		// Full set 3 with way 0 as the next victim
		clean_fill(32'h0000_0030);
		clean_fill(32'h0000_0130);
		clean_fill(32'h0000_0230);
		clean_fill(32'h0000_0330);
		// Hit on way 0 moves the victim to way 2
		load_hit(32'h0000_0030, 32'h0000_0030);
		clean_fill(32'h0000_0430);
		load_miss(32'h0000_0134);
		// Another hit on way 0 makes the tree pick way 3
		load_hit(32'h0000_0034, 32'h0000_0031);
		clean_fill(32'h0000_0530);
		load_miss(32'h0000_0338);
		load_hit(32'h0000_0238, 32'h0000_0232);
		load_hit(32'h0000_0538, 32'h0000_0532);

		// Consecutive loads across sets
		load_hit(32'h0000_1414, 32'h0000_1411);
		load_hit(32'h0000_0228, 32'h0000_0222);
		load_hit(32'h0000_053c, 32'h0000_0533);
		load_miss(32'h0000_0048);
		load_hit(32'h0000_121c, 32'h0000_1213);

		wait_reset_release();
		#DRIVE_DELAY;
		check_quiet();
		run_table();
		wait_pipeline_drain();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- filelist.f
source/l2_cache_pkg.sv
source/sram_1r1w.sv
source/cache_lru.sv
source/l2_cache_tag.sv
source/l2_cache_read.sv
source/l2_cache.sv
verif/l2_cache_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the L2 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module l2_cache_tb -f filelist.f -o l2_cache_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/l2_cache_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
